//--- decode_pkg.sv
package decode_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int IMM_W      = 16;
    localparam int JIDX_W     = 26;

    localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31;  // jal / bgezal / bltzal

    // primary opcode, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_REGIMM  = 6'h01,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_BLEZ    = 6'h06,
        OP_BGTZ    = 6'h07,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LB      = 6'h20,
        OP_LH      = 6'h21,
        OP_LW      = 6'h23,
        OP_LBU     = 6'h24,
        OP_LHU     = 6'h25,
        OP_SB      = 6'h28,
        OP_SH      = 6'h29,
        OP_SW      = 6'h2b
    } opcode_e;

    // special function field, inst[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_SLLV = 6'h04,
        FN_SRLV = 6'h06,
        FN_SRAV = 6'h07,
        FN_JR   = 6'h08,
        FN_JALR = 6'h09,
        FN_ADD  = 6'h20,
        FN_ADDU = 6'h21,
        FN_SUB  = 6'h22,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [4:0] {
        RI_BLTZ   = 5'h00,
        RI_BGEZ   = 5'h01,
        RI_BLTZAL = 5'h10,
        RI_BGEZAL = 5'h11
    } regimm_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR,
        ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {SRC1_RS, SRC1_SA, SRC1_PC} src1_sel_e;

    typedef enum logic [1:0] {SRC2_RT, SRC2_SIMM, SRC2_UIMM, SRC2_EIGHT} src2_sel_e;

    typedef enum logic [3:0] {
        MEM_NONE, MEM_LW, MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_SW, MEM_SB, MEM_SH
    } mem_op_e;

    // link variants share the base kind
    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BGEZ, BR_BGTZ, BR_BLEZ, BR_BLTZ, BR_J, BR_JR
    } br_op_e;

endpackage

//--- inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import decode_pkg::*; (
    input  logic [XLEN-1:0]       inst,
    output alu_op_e               alu_op,
    output src1_sel_e             src1_sel,
    output src2_sel_e             src2_sel,
    output mem_op_e               mem_op,
    output br_op_e                br_op,
    output logic                  gr_we,
    output logic [REG_ADDR_W-1:0] dest,
    output logic                  uses_rs,
    output logic                  uses_rt
);

    logic [5:0]            op;
    logic [5:0]            funct;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;
    logic                  imm_wr;   // writes rt from rs op imm
    logic                  link_wr;  // writes pc + 8
    logic                  dst_r31;

    assign op    = inst[31:26];
    assign rt    = inst[20:16];
    assign rd    = inst[15:11];
    assign funct = inst[5:0];

    always_comb begin
        alu_op   = ALU_ADD;
        src1_sel = SRC1_RS;
        src2_sel = SRC2_RT;
        mem_op   = MEM_NONE;
        br_op    = BR_NONE;
        gr_we    = 1'b0;
        uses_rs  = 1'b0;
        uses_rt  = 1'b0;
        imm_wr   = 1'b0;
        link_wr  = 1'b0;
        dst_r31  = 1'b0;
        case (op)
            OP_SPECIAL: begin
                gr_we   = 1'b1;
                uses_rs = 1'b1;
                uses_rt = 1'b1;
                case (funct)
                    FN_ADD, FN_ADDU: alu_op = ALU_ADD;
                    FN_SUB, FN_SUBU: alu_op = ALU_SUB;
                    FN_SLT:          alu_op = ALU_SLT;
                    FN_SLTU:         alu_op = ALU_SLTU;
                    FN_AND:          alu_op = ALU_AND;
                    FN_OR:           alu_op = ALU_OR;
                    FN_XOR:          alu_op = ALU_XOR;
                    FN_NOR:          alu_op = ALU_NOR;
                    FN_SLLV:         alu_op = ALU_SLL;
                    FN_SRLV:         alu_op = ALU_SRL;
                    FN_SRAV:         alu_op = ALU_SRA;
                    FN_SLL, FN_SRL, FN_SRA: begin
                        alu_op   = (funct == FN_SLL) ? ALU_SLL :
                                   (funct == FN_SRL) ? ALU_SRL : ALU_SRA;
                        src1_sel = SRC1_SA;  // shift by inst[10:6]
                        uses_rs  = 1'b0;
                    end
                    FN_JR: begin
                        br_op   = BR_JR;
                        gr_we   = 1'b0;
                        uses_rt = 1'b0;
                    end
                    FN_JALR: begin
                        br_op   = BR_JR;
                        link_wr = 1'b1;  // link goes to rd
                        uses_rt = 1'b0;
                    end
                    default: begin
                        gr_we   = 1'b0;
                        uses_rs = 1'b0;
                        uses_rt = 1'b0;
                    end
                endcase
            end
            OP_REGIMM: begin
                uses_rs = 1'b1;
                case (rt)
                    RI_BLTZ: br_op = BR_BLTZ;
                    RI_BGEZ: br_op = BR_BGEZ;
                    RI_BLTZAL, RI_BGEZAL: begin
                        br_op   = (rt == RI_BLTZAL) ? BR_BLTZ : BR_BGEZ;
                        link_wr = 1'b1;
                        dst_r31 = 1'b1;
                    end
                    default: uses_rs = 1'b0;
                endcase
            end
            OP_J: br_op = BR_J;
            OP_JAL: begin
                br_op   = BR_J;
                link_wr = 1'b1;
                dst_r31 = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                br_op   = (op == OP_BEQ) ? BR_BEQ : BR_BNE;
                uses_rs = 1'b1;
                uses_rt = 1'b1;
            end
            OP_BLEZ, OP_BGTZ: begin
                br_op   = (op == OP_BLEZ) ? BR_BLEZ : BR_BGTZ;
                uses_rs = 1'b1;
            end
            OP_ADDI, OP_ADDIU: begin
                imm_wr   = 1'b1;
                src2_sel = SRC2_SIMM;
            end
            OP_SLTI, OP_SLTIU: begin
                alu_op   = (op == OP_SLTI) ? ALU_SLT : ALU_SLTU;
                imm_wr   = 1'b1;
                src2_sel = SRC2_SIMM;
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                alu_op   = (op == OP_ANDI) ? ALU_AND :
                           (op == OP_ORI)  ? ALU_OR  : ALU_XOR;
                imm_wr   = 1'b1;
                src2_sel = SRC2_UIMM;  // logical ops zero-extend
            end
            OP_LUI: begin
                alu_op   = ALU_LUI;
                src2_sel = SRC2_SIMM;
                gr_we    = 1'b1;
            end
            OP_LW, OP_LB, OP_LBU, OP_LH, OP_LHU: begin
                mem_op   = (op == OP_LW)  ? MEM_LW  :
                           (op == OP_LB)  ? MEM_LB  :
                           (op == OP_LBU) ? MEM_LBU :
                           (op == OP_LH)  ? MEM_LH  : MEM_LHU;
                imm_wr   = 1'b1;
                src2_sel = SRC2_SIMM;  // address = rs + simm
            end
            OP_SW, OP_SB, OP_SH: begin
                mem_op   = (op == OP_SW) ? MEM_SW :
                           (op == OP_SB) ? MEM_SB : MEM_SH;
                src2_sel = SRC2_SIMM;
                uses_rs  = 1'b1;
                uses_rt  = 1'b1;  // store data
            end
            default: ;
        endcase
        if (imm_wr) begin
            gr_we   = 1'b1;
            uses_rs = 1'b1;
        end
        if (link_wr) begin
            gr_we    = 1'b1;
            src1_sel = SRC1_PC;
            src2_sel = SRC2_EIGHT;
        end
    end

    // loads, immediates and lui all land in rt
    assign dest = dst_r31                      ? LINK_REG :
                  (imm_wr || op == OP_LUI)     ? rt       : rd;

endmodule

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file import decode_pkg::*; (
    input  logic                  clk,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] waddr,
    input  logic [XLEN-1:0]       wdata,
    input  logic [REG_ADDR_W-1:0] raddr1,
    input  logic [REG_ADDR_W-1:0] raddr2,
    output logic [XLEN-1:0]       rdata1,
    output logic [XLEN-1:0]       rdata2
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 never written, so mask it on read
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- operand_hazard.sv
`timescale 1ns/1ps

module operand_hazard import decode_pkg::*; (
    input  logic [REG_ADDR_W-1:0] rs,
    input  logic [REG_ADDR_W-1:0] rt,
    input  logic                  uses_rs,
    input  logic                  uses_rt,
    input  logic [XLEN-1:0]       rf_rdata1,
    input  logic [XLEN-1:0]       rf_rdata2,
    input  logic                  es_wr_en,
    input  logic [REG_ADDR_W-1:0] es_dest,
    input  logic                  es_fwd_valid,
    input  logic [XLEN-1:0]       es_fwd_data,
    input  logic                  ms_wr_en,
    input  logic [REG_ADDR_W-1:0] ms_dest,
    input  logic                  ms_fwd_valid,
    input  logic [XLEN-1:0]       ms_fwd_data,
    input  logic                  ws_wr_en,
    input  logic [REG_ADDR_W-1:0] ws_dest,
    input  logic                  ws_fwd_valid,
    input  logic [XLEN-1:0]       ws_fwd_data,
    output logic [XLEN-1:0]       rs_value,
    output logic [XLEN-1:0]       rt_value,
    output logic                  ready_go
);

    logic       rs_chk;
    logic       rt_chk;
    logic [2:0] rs_hit;     // {es, ms, ws}
    logic [2:0] rt_hit;
    logic [2:0] fwd_valid;
    logic       rs_stall;
    logic       rt_stall;

    // nearest hit wins; returns {stall, operand}
    function automatic logic [XLEN:0] merge_operand(
        input logic [2:0]      hit,
        input logic [2:0]      fwd_ok,
        input logic [XLEN-1:0] es_data,
        input logic [XLEN-1:0] ms_data,
        input logic [XLEN-1:0] ws_data,
        input logic [XLEN-1:0] rf_data
    );
        if (hit[2]) begin
            return {!fwd_ok[2], es_data};
        end else if (hit[1]) begin
            return {!fwd_ok[1], ms_data};
        end else if (hit[0]) begin
            return {!fwd_ok[0], ws_data};
        end
        return {1'b0, rf_data};
    endfunction

    // r0 reads are constant, never a hazard
    assign rs_chk = uses_rs && (rs != '0);
    assign rt_chk = uses_rt && (rt != '0);

    assign rs_hit = {es_wr_en && es_dest == rs,
                     ms_wr_en && ms_dest == rs,
                     ws_wr_en && ws_dest == rs} & {3{rs_chk}};
    assign rt_hit = {es_wr_en && es_dest == rt,
                     ms_wr_en && ms_dest == rt,
                     ws_wr_en && ws_dest == rt} & {3{rt_chk}};

    assign fwd_valid = {es_fwd_valid, ms_fwd_valid, ws_fwd_valid};

    assign {rs_stall, rs_value} = merge_operand(rs_hit, fwd_valid, es_fwd_data,
                                                ms_fwd_data, ws_fwd_data, rf_rdata1);
    assign {rt_stall, rt_value} = merge_operand(rt_hit, fwd_valid, es_fwd_data,
                                                ms_fwd_data, ws_fwd_data, rf_rdata2);

    assign ready_go = !rs_stall && !rt_stall;

endmodule

//--- branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve import decode_pkg::*; (
    input  logic              valid,
    input  br_op_e            br_op,
    input  logic [XLEN-1:0]   pc,
    input  logic [IMM_W-1:0]  imm,
    input  logic [JIDX_W-1:0] jidx,
    input  logic [XLEN-1:0]   rs_value,
    input  logic [XLEN-1:0]   rt_value,
    output logic              br_taken,
    output logic [XLEN-1:0]   br_target
);

    logic [XLEN-1:0] seq_pc;  // delay slot address
    logic [XLEN-1:0] br_offset;
    logic            rs_neg;
    logic            rs_zero;
    logic            cond;

    assign seq_pc    = pc + 32'd4;
    assign br_offset = {{(XLEN-IMM_W-2){imm[IMM_W-1]}}, imm, 2'b00};
    assign rs_neg    = rs_value[XLEN-1];
    assign rs_zero   = (rs_value == '0);

    always_comb begin
        case (br_op)
            BR_BEQ:      cond = (rs_value == rt_value);
            BR_BNE:      cond = (rs_value != rt_value);
            BR_BGEZ:     cond = !rs_neg;
            BR_BGTZ:     cond = !rs_neg && !rs_zero;
            BR_BLEZ:     cond = rs_neg || rs_zero;
            BR_BLTZ:     cond = rs_neg;
            BR_J, BR_JR: cond = 1'b1;
            default:     cond = 1'b0;
        endcase
    end

    always_comb begin
        case (br_op)
            BR_J:    br_target = {seq_pc[XLEN-1:JIDX_W+2], jidx, 2'b00};
            BR_JR:   br_target = rs_value;
            default: br_target = seq_pc + br_offset;
        endcase
    end

    assign br_taken = valid && cond;

endmodule

//--- decode_stage.sv
`timescale 1ns/1ps

module decode_stage import decode_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  in_valid,
    input  logic [XLEN-1:0]       in_inst,
    input  logic [XLEN-1:0]       in_pc,
    output logic                  in_allowin,
    input  logic                  out_allowin,
    output logic                  out_valid,
    output alu_op_e               out_alu_op,
    output src1_sel_e             out_src1_sel,
    output src2_sel_e             out_src2_sel,
    output mem_op_e               out_mem_op,
    output logic                  out_gr_we,
    output logic [REG_ADDR_W-1:0] out_dest,
    output logic [IMM_W-1:0]      out_imm,
    output logic [REG_ADDR_W-1:0] out_sa,
    output logic [XLEN-1:0]       out_rs_value,
    output logic [XLEN-1:0]       out_rt_value,
    output logic [XLEN-1:0]       out_pc,
    input  logic                  rf_we,
    input  logic [REG_ADDR_W-1:0] rf_waddr,
    input  logic [XLEN-1:0]       rf_wdata,
    input  logic                  es_wr_en,
    input  logic [REG_ADDR_W-1:0] es_dest,
    input  logic                  es_fwd_valid,
    input  logic [XLEN-1:0]       es_fwd_data,
    input  logic                  ms_wr_en,
    input  logic [REG_ADDR_W-1:0] ms_dest,
    input  logic                  ms_fwd_valid,
    input  logic [XLEN-1:0]       ms_fwd_data,
    input  logic                  ws_wr_en,
    input  logic [REG_ADDR_W-1:0] ws_dest,
    input  logic                  ws_fwd_valid,
    input  logic [XLEN-1:0]       ws_fwd_data,
    output logic                  br_taken,
    output logic [XLEN-1:0]       br_target
);

    logic                  valid;
    logic [XLEN-1:0]       inst_r;
    logic [XLEN-1:0]       pc_r;
    logic                  ready_go;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic                  uses_rs;
    logic                  uses_rt;
    logic [XLEN-1:0]       rf_rdata1;
    logic [XLEN-1:0]       rf_rdata2;
    br_op_e                br_op;

    assign in_allowin = !valid || (ready_go && out_allowin);
    assign out_valid  = valid && ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;  // beats a same-cycle accept
        end else if (in_allowin) begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            inst_r <= in_inst;
            pc_r   <= in_pc;
        end
    end

    assign rs      = inst_r[25:21];
    assign rt      = inst_r[20:16];
    assign out_sa  = inst_r[10:6];
    assign out_imm = inst_r[IMM_W-1:0];
    assign out_pc  = pc_r;

    inst_decoder u_dec (
        .inst     (inst_r),
        .alu_op   (out_alu_op),
        .src1_sel (out_src1_sel),
        .src2_sel (out_src2_sel),
        .mem_op   (out_mem_op),
        .br_op    (br_op),
        .gr_we    (out_gr_we),
        .dest     (out_dest),
        .uses_rs  (uses_rs),
        .uses_rt  (uses_rt)
    );

    reg_file u_rf (
        .clk    (clk),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    operand_hazard u_hazard (
        .rs           (rs),
        .rt           (rt),
        .uses_rs      (uses_rs),
        .uses_rt      (uses_rt),
        .rf_rdata1    (rf_rdata1),
        .rf_rdata2    (rf_rdata2),
        .es_wr_en     (es_wr_en),
        .es_dest      (es_dest),
        .es_fwd_valid (es_fwd_valid),
        .es_fwd_data  (es_fwd_data),
        .ms_wr_en     (ms_wr_en),
        .ms_dest      (ms_dest),
        .ms_fwd_valid (ms_fwd_valid),
        .ms_fwd_data  (ms_fwd_data),
        .ws_wr_en     (ws_wr_en),
        .ws_dest      (ws_dest),
        .ws_fwd_valid (ws_fwd_valid),
        .ws_fwd_data  (ws_fwd_data),
        .rs_value     (out_rs_value),
        .rt_value     (out_rt_value),
        .ready_go     (ready_go)
    );

    branch_resolve u_br (
        .valid     (valid),
        .br_op     (br_op),
        .pc        (pc_r),
        .imm       (inst_r[IMM_W-1:0]),
        .jidx      (inst_r[JIDX_W-1:0]),
        .rs_value  (out_rs_value),
        .rt_value  (out_rt_value),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- decode_ref_model.svh
`ifndef DECODE_REF_MODEL_SVH
`define DECODE_REF_MODEL_SVH

typedef struct packed {
    alu_op_e               alu_op;
    src1_sel_e             src1_sel;
    src2_sel_e             src2_sel;
    mem_op_e               mem_op;
    br_op_e                br_op;
    logic                  gr_we;
    logic [REG_ADDR_W-1:0] dest;
    logic                  uses_rs;
    logic                  uses_rt;
} dec_t;

function automatic dec_t model_decode(input logic [XLEN-1:0] w);
    dec_t                  d;
    logic [5:0]            op;
    logic [5:0]            fn;
    logic [REG_ADDR_W-1:0] rt;
    logic                  link;    // writes the return address
    logic                  imm_wr;  // rt gets rs op immediate, loads too
    op     = w[31:26];
    fn     = w[5:0];
    rt     = w[20:16];
    link   = 1'b0;
    d      = '{ALU_ADD, SRC1_RS, SRC2_RT, MEM_NONE, BR_NONE, 1'b0, w[15:11], 1'b0, 1'b0};
    case (op)
        OP_SPECIAL: begin
            if (fn inside {FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_JR, FN_JALR,
                           FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
                           FN_SLT, FN_SLTU}) begin
                d.gr_we   = (fn != FN_JR);
                d.uses_rs = !(fn inside {FN_SLL, FN_SRL, FN_SRA});
                d.uses_rt = !(fn inside {FN_JR, FN_JALR});
            end
            case (fn)
                FN_SUB, FN_SUBU: d.alu_op = ALU_SUB;
                FN_SLT:          d.alu_op = ALU_SLT;
                FN_SLTU:         d.alu_op = ALU_SLTU;
                FN_AND:          d.alu_op = ALU_AND;
                FN_OR:           d.alu_op = ALU_OR;
                FN_XOR:          d.alu_op = ALU_XOR;
                FN_NOR:          d.alu_op = ALU_NOR;
                FN_SLL, FN_SLLV: d.alu_op = ALU_SLL;
                FN_SRL, FN_SRLV: d.alu_op = ALU_SRL;
                FN_SRA, FN_SRAV: d.alu_op = ALU_SRA;
                FN_JR:           d.br_op  = BR_JR;
                FN_JALR: begin
                    d.br_op = BR_JR;
                    link    = 1'b1;
                end
                default: ;
            endcase
            if (fn inside {FN_SLL, FN_SRL, FN_SRA}) begin
                d.src1_sel = SRC1_SA;
            end
        end
        OP_REGIMM: begin
            case (rt)
                RI_BLTZ, RI_BLTZAL: d.br_op = BR_BLTZ;
                RI_BGEZ, RI_BGEZAL: d.br_op = BR_BGEZ;
                default: ;
            endcase
            d.uses_rs = (d.br_op != BR_NONE);
            link      = rt[4] && (d.br_op != BR_NONE);  // the -al forms
        end
        OP_J: d.br_op = BR_J;
        OP_JAL: begin
            d.br_op = BR_J;
            link    = 1'b1;
        end
        OP_BEQ, OP_BNE: begin
            d.br_op   = (op == OP_BEQ) ? BR_BEQ : BR_BNE;
            d.uses_rs = 1'b1;
            d.uses_rt = 1'b1;
        end
        OP_BLEZ, OP_BGTZ: begin
            d.br_op   = (op == OP_BLEZ) ? BR_BLEZ : BR_BGTZ;
            d.uses_rs = 1'b1;
        end
        OP_SLTI:  d.alu_op = ALU_SLT;
        OP_SLTIU: d.alu_op = ALU_SLTU;
        OP_ANDI:  d.alu_op = ALU_AND;
        OP_ORI:   d.alu_op = ALU_OR;
        OP_XORI:  d.alu_op = ALU_XOR;
        OP_LUI: begin
            d.alu_op   = ALU_LUI;
            d.src2_sel = SRC2_SIMM;
            d.gr_we    = 1'b1;
            d.dest     = rt;
        end
        OP_LW:  d.mem_op = MEM_LW;
        OP_LB:  d.mem_op = MEM_LB;
        OP_LBU: d.mem_op = MEM_LBU;
        OP_LH:  d.mem_op = MEM_LH;
        OP_LHU: d.mem_op = MEM_LHU;
        OP_SW:  d.mem_op = MEM_SW;
        OP_SB:  d.mem_op = MEM_SB;
        OP_SH:  d.mem_op = MEM_SH;
        default: ;
    endcase
    imm_wr = (op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI}) ||
             (d.mem_op inside {MEM_LW, MEM_LB, MEM_LBU, MEM_LH, MEM_LHU});
    if (d.mem_op inside {MEM_SW, MEM_SB, MEM_SH}) begin
        d.src2_sel = SRC2_SIMM;
        d.uses_rs  = 1'b1;
        d.uses_rt  = 1'b1;
    end
    if (imm_wr) begin
        d.gr_we    = 1'b1;
        d.uses_rs  = 1'b1;
        d.dest     = rt;
        d.src2_sel = (op inside {OP_ANDI, OP_ORI, OP_XORI}) ? SRC2_UIMM : SRC2_SIMM;
    end
    if (link) begin
        d.gr_we    = 1'b1;
        d.src1_sel = SRC1_PC;
        d.src2_sel = SRC2_EIGHT;
        if (op != OP_SPECIAL) begin
            d.dest = LINK_REG;  // jalr keeps rd
        end
    end
    return d;
endfunction

// {stall, value}, nearest matching stage decides
function automatic logic [XLEN:0] model_operand(input logic [REG_ADDR_W-1:0] r,
                                                input logic used);
    if (used && r != '0) begin
        if (es_wr_en && es_dest == r) begin
            return {!es_fwd_valid, es_fwd_data};
        end
        if (ms_wr_en && ms_dest == r) begin
            return {!ms_fwd_valid, ms_fwd_data};
        end
        if (ws_wr_en && ws_dest == r) begin
            return {!ws_fwd_valid, ws_fwd_data};
        end
    end
    return {1'b0, model_regs[r]};
endfunction

// {taken, target}
function automatic logic [XLEN:0] model_branch(input br_op_e op, input logic [XLEN-1:0] w,
                                               input logic [XLEN-1:0] pc,
                                               input logic [XLEN-1:0] a,
                                               input logic [XLEN-1:0] b);
    logic [XLEN-1:0] seq;
    logic [XLEN-1:0] tgt;
    logic            taken;
    seq = pc + 4;
    tgt = seq + ({{16{w[15]}}, w[15:0]} << 2);
    case (op)
        BR_BEQ:  taken = (a == b);
        BR_BNE:  taken = (a != b);
        BR_BGEZ: taken = ($signed(a) >= 0);
        BR_BGTZ: taken = ($signed(a) > 0);
        BR_BLEZ: taken = ($signed(a) <= 0);
        BR_BLTZ: taken = ($signed(a) < 0);
        BR_J: begin
            taken = 1'b1;
            tgt   = {seq[31:28], w[25:0], 2'b00};
        end
        BR_JR: begin
            taken = 1'b1;
            tgt   = a;
        end
        default: taken = 1'b0;
    endcase
    return {taken, tgt};
endfunction

`endif

//--- decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb import decode_pkg::*; ();

    localparam int NUM_TX = 2000;

    logic                  clk;
    logic                  reset;
    logic                  flush;
    logic                  in_valid;
    logic [XLEN-1:0]       in_inst;
    logic [XLEN-1:0]       in_pc;
    logic                  in_allowin;
    logic                  out_allowin;
    logic                  out_valid;
    alu_op_e               out_alu_op;
    src1_sel_e             out_src1_sel;
    src2_sel_e             out_src2_sel;
    mem_op_e               out_mem_op;
    logic                  out_gr_we;
    logic [REG_ADDR_W-1:0] out_dest;
    logic [IMM_W-1:0]      out_imm;
    logic [REG_ADDR_W-1:0] out_sa;
    logic [XLEN-1:0]       out_rs_value;
    logic [XLEN-1:0]       out_rt_value;
    logic [XLEN-1:0]       out_pc;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;
    logic                  es_wr_en;
    logic [REG_ADDR_W-1:0] es_dest;
    logic                  es_fwd_valid;
    logic [XLEN-1:0]       es_fwd_data;
    logic                  ms_wr_en;
    logic [REG_ADDR_W-1:0] ms_dest;
    logic                  ms_fwd_valid;
    logic [XLEN-1:0]       ms_fwd_data;
    logic                  ws_wr_en;
    logic [REG_ADDR_W-1:0] ws_dest;
    logic                  ws_fwd_valid;
    logic [XLEN-1:0]       ws_fwd_data;
    logic                  br_taken;
    logic [XLEN-1:0]       br_target;

    logic [XLEN-1:0] model_regs [NUM_REGS];
    logic            m_valid;  // model of the stage register
    logic [XLEN-1:0] m_inst;
    logic [XLEN-1:0] m_pc;
    int              seed;
    int              transfers;
    int              stall_cycles;
    int              taken_seen;
    int              flush_drops;

    logic [5:0] fn_tab [18] = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_JR,
                                FN_JALR, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR,
                                FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
    logic [5:0] op_tab [22] = '{OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_ADDI,
                                OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
                                OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW};
    logic [4:0] ri_tab [4]  = '{RI_BLTZ, RI_BGEZ, RI_BLTZAL, RI_BGEZAL};

    `include "decode_ref_model.svh"

    tb_clock_gen clk_gen (
        .clk   (clk),
        .reset (reset)
    );

    decode_stage uut (.*);

    task automatic compare(input logic [63:0] actual, input logic [63:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("[FAIL] time %0t: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("Something failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic one_in(input int n);
        return ($unsigned($random(seed)) % n) == 0;
    endfunction

    // r0-r3 and r28-r31, so hazards hit often
    function automatic logic [REG_ADDR_W-1:0] pick_reg();
        int unsigned r;
        r = $unsigned($random(seed)) % 8;
        return (r < 4) ? REG_ADDR_W'(r) : REG_ADDR_W'(r + 24);
    endfunction

    function automatic logic [XLEN-1:0] random_inst();
        logic [XLEN-1:0] w;
        int unsigned     kind;
        w        = $random(seed);
        w[25:21] = pick_reg();
        w[20:16] = pick_reg();
        w[15:11] = pick_reg();
        kind     = $unsigned($random(seed)) % 16;
        if (kind < 5) begin
            w[31:26] = OP_SPECIAL;
            w[5:0]   = fn_tab[$unsigned($random(seed)) % 18];
        end else if (kind < 7) begin
            w[31:26] = OP_REGIMM;
            w[20:16] = ri_tab[$unsigned($random(seed)) % 4];
        end else if (kind < 15) begin
            w[31:26] = op_tab[$unsigned($random(seed)) % 22];
        end
        return w;  // kind 15 keeps a raw word, mostly illegal
    endfunction

    task automatic drive_random();
        in_valid     <= !one_in(4);
        in_inst      <= random_inst();
        in_pc        <= $random(seed) & ~32'h3;
        out_allowin  <= !one_in(4);
        flush        <= one_in(40);
        rf_we        <= one_in(2);
        rf_waddr     <= pick_reg();
        rf_wdata     <= $random(seed);
        es_wr_en     <= one_in(2);
        es_dest      <= pick_reg();
        es_fwd_valid <= !one_in(3);
        es_fwd_data  <= $random(seed);
        ms_wr_en     <= one_in(2);
        ms_dest      <= pick_reg();
        ms_fwd_valid <= !one_in(3);
        ms_fwd_data  <= $random(seed);
        ws_wr_en     <= one_in(2);
        ws_dest      <= pick_reg();
        ws_fwd_valid <= !one_in(3);
        ws_fwd_data  <= $random(seed);
    endtask

    task automatic check_stage();
        dec_t          d;
        logic [XLEN:0] a;
        logic [XLEN:0] b;
        logic [XLEN:0] br;
        logic          ready;
        logic          allow;
        d     = model_decode(m_inst);
        a     = model_operand(m_inst[25:21], d.uses_rs);
        b     = model_operand(m_inst[20:16], d.uses_rt);
        ready = !a[XLEN] && !b[XLEN];
        allow = !m_valid || (ready && out_allowin);
        compare(out_valid, m_valid && ready, "out_valid");
        compare(in_allowin, allow, "in_allowin");
        if (!m_valid) begin
            compare(br_taken, 1'b0, "br_taken with empty stage");
        end else if (!ready) begin
            stall_cycles++;
        end else begin
            compare(out_alu_op, d.alu_op, "out_alu_op");
            compare(out_src1_sel, d.src1_sel, "out_src1_sel");
            compare(out_src2_sel, d.src2_sel, "out_src2_sel");
            compare(out_mem_op, d.mem_op, "out_mem_op");
            compare(out_gr_we, d.gr_we, "out_gr_we");
            compare(out_dest, d.dest, "out_dest");
            compare(out_imm, m_inst[15:0], "out_imm");
            compare(out_sa, m_inst[10:6], "out_sa");
            compare(out_pc, m_pc, "out_pc");
            compare(out_rs_value, a[XLEN-1:0], "out_rs_value");
            compare(out_rt_value, b[XLEN-1:0], "out_rt_value");
            br = model_branch(d.br_op, m_inst, m_pc, a[XLEN-1:0], b[XLEN-1:0]);
            compare(br_taken, br[XLEN], "br_taken");
            if (d.br_op != BR_NONE) begin
                compare(br_target, br[XLEN-1:0], "br_target");
            end
            if (br[XLEN]) begin
                taken_seen++;
            end
            if (out_allowin && !flush) begin
                transfers++;
            end
        end
        if (m_valid && flush) begin
            flush_drops++;
        end
        // what the coming edge does to the stage
        if (flush) begin
            m_valid = 1'b0;
        end else if (allow) begin
            m_valid = in_valid;
            if (in_valid) begin
                m_inst = in_inst;
                m_pc   = in_pc;
            end
        end
    endtask

    always @(negedge clk) begin
        if (reset) begin
            compare(out_valid, 1'b0, "out_valid in reset");
            compare(br_taken, 1'b0, "br_taken in reset");
            compare(in_allowin, 1'b1, "in_allowin in reset");
            m_valid = 1'b0;
        end else begin
            check_stage();
        end
        if (rf_we && rf_waddr != '0) begin
            model_regs[rf_waddr] = rf_wdata;  // lands on the coming edge
        end
    end

    initial begin
        #(NUM_TX * 20 * 4);
        $display("Timeout: only %0d of %0d transfers completed", transfers, NUM_TX);
        $display("Something failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed          = 2505;
        transfers     = 0;
        stall_cycles  = 0;
        taken_seen    = 0;
        flush_drops   = 0;
        m_valid       = 1'b0;
        m_inst        = '0;
        m_pc          = '0;
        model_regs[0] = '0;
        flush         = 1'b0;
        in_valid      = 1'b0;
        in_inst       = '0;
        in_pc         = '0;
        out_allowin   = 1'b0;
        rf_we         = 1'b0;
        rf_waddr      = '0;
        rf_wdata      = '0;
        es_wr_en      = 1'b0;
        es_dest       = '0;
        es_fwd_valid  = 1'b0;
        es_fwd_data   = '0;
        ms_wr_en      = 1'b0;
        ms_dest       = '0;
        ms_fwd_valid  = 1'b0;
        ms_fwd_data   = '0;
        ws_wr_en      = 1'b0;
        ws_dest       = '0;
        ws_fwd_valid  = 1'b0;
        ws_fwd_data   = '0;
        // fill every register once before any instruction
        for (int i = 1; i < NUM_REGS; i++) begin
            @(posedge clk);
            rf_we    <= 1'b1;
            rf_waddr <= REG_ADDR_W'(i);
            rf_wdata <= 32'h9e37_79b9 * (i + 1);
        end
        @(posedge clk);
        rf_we <= 1'b0;
        while (transfers < NUM_TX) begin
            @(posedge clk);
            drive_random();
        end
        @(posedge clk);  // last negedge check has run by now
        if (stall_cycles == 0 || taken_seen == 0 || flush_drops == 0) begin
            $display("Coverage hole: %0d stall cycles, %0d taken branches, %0d flushed",
                     stall_cycles, taken_seen, flush_drops);
            $display("Something failed");
            $fatal(1, "coverage hole");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

//--- compile.f
+incdir+.
decode_pkg.sv
inst_decoder.sv
reg_file.sv
operand_hazard.sv
branch_resolve.sv
decode_stage.sv
tb_clock_gen.sv
decode_stage_tb.sv
